// File: accel_pkg.sv
package accel_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int N_LANES         = 8;
    localparam int I_WIDTH         = 8;
    localparam int F_WIDTH         = 8;
    localparam int DRAM_DATA_WIDTH = 32;
    localparam int DRAM_ADDR_WIDTH = 18;
    localparam int ACC_WIDTH       = 32;
    localparam int ROW_ADDR_WIDTH  = 4;

    // one row spans two dram words
    localparam int WORDS_PER_ROW   = (N_LANES * I_WIDTH) / DRAM_DATA_WIDTH;

    // row count 1..16 needs one bit more than the row address
    localparam int ROW_CNT_WIDTH   = ROW_ADDR_WIDTH + 1;

    ////////////////////////////////////////
    // row payloads, lane 0 in the low bits
    ////////////////////////////////////////

    typedef logic signed [I_WIDTH-1:0] in_lane_t;
    typedef logic signed [F_WIDTH-1:0] wt_lane_t;

    typedef struct packed {
        in_lane_t [N_LANES-1:0] lane;
    } in_row_t;

    typedef struct packed {
        wt_lane_t [N_LANES-1:0] lane;
    } wt_row_t;

    ////////////////////////////////////////
    // job and bus structs
    ////////////////////////////////////////

    typedef struct packed {
        logic [DRAM_ADDR_WIDTH-1:0] in_base;
        logic [DRAM_ADDR_WIDTH-1:0] wt_base;
        logic [ROW_CNT_WIDTH-1:0]   n_rows;
    } job_t;

    typedef struct packed {
        logic [DRAM_ADDR_WIDTH-1:0] addr;
    } dram_req_t;

    typedef struct packed {
        logic [DRAM_ADDR_WIDTH-1:0] base;
        logic [ROW_CNT_WIDTH-1:0]   n_rows;
    } fetch_cmd_t;

endpackage

// File: dram_arbiter.sv
module dram_arbiter (
    input  logic                  clk_i,
    input  logic                  rd_weight_rst,
    input  accel_pkg::dram_req_t  in_req_i,
    input  logic                  in_req_valid_i,
    output logic                  in_req_ready_o,
    input  accel_pkg::dram_req_t  wt_req_i,
    input  logic                  wt_req_valid_i,
    output logic                  wt_req_ready_o,
    output accel_pkg::dram_req_t  dram_req_o,
    output logic                  dram_req_valid_o,
    input  logic                  dram_req_ready_i,
    input  logic                  dram_rsp_valid_i,
    output logic                  in_rsp_valid_o,
    output logic                  wt_rsp_valid_o
);

    localparam int WPR = accel_pkg::WORDS_PER_ROW;
    localparam int CW  = $clog2(WPR + 1);

    // owner: 0 input fetcher, 1 weight fetcher
    logic          locked;
    logic          owner;
    logic          prio;
    logic          sel;
    logic          open;
    logic          fire;
    logic [CW-1:0] req_cnt;
    logic [CW-1:0] rsp_cnt;

    // a pending valid locks the port, so a stalled request never switches source
    always_comb begin
        if (locked) begin
            sel = owner;
        end else if (in_req_valid_i && wt_req_valid_i) begin
            sel = prio;
        end else begin
            sel = wt_req_valid_i;
        end
    end

    // at most one row of words per lock
    assign open             = (req_cnt != CW'(WPR));
    assign dram_req_o       = sel ? wt_req_i : in_req_i;
    assign dram_req_valid_o = open && (sel ? wt_req_valid_i : in_req_valid_i);
    assign in_req_ready_o   = open && !sel && dram_req_ready_i;
    assign wt_req_ready_o   = open && sel && dram_req_ready_i;
    assign fire             = dram_req_valid_o && dram_req_ready_i;

    assign in_rsp_valid_o = dram_rsp_valid_i && locked && !owner;
    assign wt_rsp_valid_o = dram_rsp_valid_i && locked && owner;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            locked  <= 1'b0;
            owner   <= 1'b0;
            prio    <= 1'b0;
            req_cnt <= '0;
            rsp_cnt <= '0;
        end else begin
            if (!locked && (in_req_valid_i || wt_req_valid_i)) begin
                locked <= 1'b1;
                owner  <= sel;
            end
            if (fire) begin
                req_cnt <= req_cnt + 1'b1;
            end
            if (locked && dram_rsp_valid_i) begin
                if (rsp_cnt == CW'(WPR - 1)) begin
                    // row complete, hand priority to the other side
                    locked  <= 1'b0;
                    prio    <= !owner;
                    req_cnt <= '0;
                    rsp_cnt <= '0;
                end else begin
                    rsp_cnt <= rsp_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: row_fetcher.sv
module row_fetcher #(
    parameter type row_t          = accel_pkg::in_row_t,
    parameter int  ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH
) (
    input  logic                                 clk_i,
    input  logic                                 rd_weight_rst,
    input  accel_pkg::fetch_cmd_t                cmd_i,
    input  logic                                 start_i,
    output logic                                 done_o,
    output accel_pkg::dram_req_t                 req_o,
    output logic                                 req_valid_o,
    input  logic                                 req_ready_i,
    input  logic                                 rsp_valid_i,
    input  logic [accel_pkg::DRAM_DATA_WIDTH-1:0] rsp_data_i,
    output logic [ROW_ADDR_WIDTH-1:0]            wr_addr_o,
    output row_t                                 wr_data_o,
    output logic                                 wr_en_o
);

    localparam int DW  = accel_pkg::DRAM_DATA_WIDTH;
    localparam int WPR = accel_pkg::WORDS_PER_ROW;
    localparam int RW  = WPR * DW;
    localparam int WCW = ROW_ADDR_WIDTH + 1 + $clog2(WPR);

    logic [accel_pkg::DRAM_ADDR_WIDTH-1:0] req_addr;
    logic [WCW-1:0]                        req_left;
    logic [$clog2(WPR)-1:0]                word_cnt;
    logic [ROW_ADDR_WIDTH:0]               rows_left;
    logic [RW-1:0]                         row_q;
    logic [RW-1:0]                         row_shift;
    logic                                  last_word;

    // words shift in from the top, word 0 ends up in the low bits
    assign row_shift = {rsp_data_i, row_q[RW-1:DW]};
    assign last_word = rsp_valid_i && (word_cnt == WPR - 1);

    assign req_o       = '{addr: req_addr};
    assign req_valid_o = (req_left != '0);

    ////////////////////////////////////////
    // request and row counters
    ////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            req_addr  <= '0;
            req_left  <= '0;
            word_cnt  <= '0;
            rows_left <= '0;
            wr_addr_o <= '0;
            wr_en_o   <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
            if (start_i) begin
                req_addr  <= cmd_i.base;
                req_left  <= WCW'(cmd_i.n_rows) * WCW'(WPR);
                word_cnt  <= '0;
                rows_left <= cmd_i.n_rows;
                wr_addr_o <= '0;
            end else begin
                if (req_valid_o && req_ready_i) begin
                    req_addr <= req_addr + 1'b1;
                    req_left <= req_left - 1'b1;
                end
                if (last_word) begin
                    word_cnt  <= '0;
                    wr_en_o   <= 1'b1;
                    rows_left <= rows_left - 1'b1;
                    done_o    <= (rows_left == 1);
                end else if (rsp_valid_i) begin
                    word_cnt <= word_cnt + 1'b1;
                end
                if (wr_en_o) begin
                    wr_addr_o <= wr_addr_o + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // row packing
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            row_q <= row_shift;
        end
        if (last_word) begin
            wr_data_o <= row_t'(row_shift);
        end
    end

endmodule

// File: row_ram.sv
module row_ram #(
    parameter type row_t          = accel_pkg::in_row_t,
    parameter int  ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH
) (
    input  logic                      clk_i,
    input  logic [ROW_ADDR_WIDTH-1:0] wr_addr_i,
    input  row_t                      wr_data_i,
    input  logic                      wr_en_i,
    input  logic [ROW_ADDR_WIDTH-1:0] rd_addr_i,
    output row_t                      rd_data_o
);

    row_t mem [2**ROW_ADDR_WIDTH];

    // read data one cycle after the address
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: mac_engine.sv
module mac_engine #(
    parameter int N_LANES        = accel_pkg::N_LANES,
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH
) (
    input  logic                                  clk_i,
    input  logic                                  rd_weight_rst,
    input  logic                                  start_i,
    input  logic [ROW_ADDR_WIDTH:0]               n_rows_i,
    output logic [ROW_ADDR_WIDTH-1:0]             rd_addr_o,
    input  accel_pkg::in_row_t                    in_row_i,
    input  accel_pkg::wt_row_t                    wt_row_i,
    output logic signed [accel_pkg::ACC_WIDTH-1:0] result_o,
    output logic                                  result_valid_o,
    input  logic                                  result_ready_i,
    output logic                                  busy_o
);

    localparam int AW = accel_pkg::ACC_WIDTH;

    logic                    rd_active;
    logic                    data_vld;
    logic                    data_last;
    logic [ROW_ADDR_WIDTH:0] rows_left;
    logic signed [AW-1:0]    acc;
    logic signed [AW-1:0]    row_sum;

    // dot product of one row pair
    always_comb begin
        row_sum = '0;
        for (int l = 0; l < N_LANES; l++) begin
            row_sum = row_sum + AW'($signed(in_row_i.lane[l]) * $signed(wt_row_i.lane[l]));
        end
    end

    ////////////////////////////////////////
    // read sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            rd_active      <= 1'b0;
            data_vld       <= 1'b0;
            data_last      <= 1'b0;
            rows_left      <= '0;
            rd_addr_o      <= '0;
            result_valid_o <= 1'b0;
        end else begin
            // ram data trails the address by one cycle
            data_vld  <= rd_active;
            data_last <= rd_active && (rows_left == 1);
            if (start_i) begin
                rd_active <= 1'b1;
                rd_addr_o <= '0;
                rows_left <= n_rows_i;
            end else if (rd_active) begin
                if (rows_left == 1) begin
                    rd_active <= 1'b0;
                end else begin
                    rd_addr_o <= rd_addr_o + 1'b1;
                end
                rows_left <= rows_left - 1'b1;
            end
            if (data_last) begin
                result_valid_o <= 1'b1;
            end else if (result_valid_o && result_ready_i) begin
                result_valid_o <= 1'b0;
            end
        end
    end

    // held steady while the result waits for ready
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc <= '0;
        end else if (data_vld) begin
            acc <= acc + row_sum;
        end
    end

    assign result_o = acc;
    assign busy_o   = rd_active || data_vld || result_valid_o;

endmodule

// File: layer_controller.sv
module layer_controller #(
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH
) (
    input  logic                    clk_i,
    input  logic                    rd_weight_rst,
    input  accel_pkg::job_t         job_i,
    input  logic                    job_valid_i,
    output logic                    job_ready_o,
    output accel_pkg::fetch_cmd_t   in_cmd_o,
    output accel_pkg::fetch_cmd_t   wt_cmd_o,
    output logic                    fetch_start_o,
    input  logic                    in_done_i,
    input  logic                    wt_done_i,
    output logic                    mac_start_o,
    output logic [ROW_ADDR_WIDTH:0] mac_n_rows_o,
    input  logic                    mac_busy_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_COMPUTE,
        ST_ACCEPT
    } state_t;

    state_t          state;
    accel_pkg::job_t job_q;
    logic            job_fire;
    logic            in_seen;
    logic            wt_seen;

    assign job_fire = (state == ST_IDLE) && job_valid_i && job_ready_o;

    assign in_cmd_o     = '{base: job_q.in_base, n_rows: job_q.n_rows};
    assign wt_cmd_o     = '{base: job_q.wt_base, n_rows: job_q.n_rows};
    assign mac_n_rows_o = job_q.n_rows;
    // compute state lasts one cycle
    assign mac_start_o  = (state == ST_COMPUTE);

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state         <= ST_IDLE;
            job_ready_o   <= 1'b0;
            fetch_start_o <= 1'b0;
            in_seen       <= 1'b0;
            wt_seen       <= 1'b0;
        end else begin
            fetch_start_o <= 1'b0;
            // the fetchers may finish in either order
            if (in_done_i) begin
                in_seen <= 1'b1;
            end
            if (wt_done_i) begin
                wt_seen <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    job_ready_o <= 1'b1;
                    if (job_fire) begin
                        job_ready_o   <= 1'b0;
                        fetch_start_o <= 1'b1;
                        state         <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if ((in_seen || in_done_i) && (wt_seen || wt_done_i)) begin
                        in_seen <= 1'b0;
                        wt_seen <= 1'b0;
                        state   <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    state <= ST_ACCEPT;
                end
                ST_ACCEPT: begin
                    // busy drops once the result handshake is done
                    if (!mac_busy_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (job_fire) begin
            job_q <= job_i;
        end
    end

endmodule

// File: conv_accel_top.sv
module conv_accel_top #(
    parameter int N_LANES        = accel_pkg::N_LANES,
    parameter int ROW_ADDR_WIDTH = accel_pkg::ROW_ADDR_WIDTH
) (
    input  logic                                  clk_i,
    input  logic                                  rd_weight_rst,
    input  accel_pkg::job_t                       job_i,
    input  logic                                  job_valid_i,
    output logic                                  job_ready_o,
    output accel_pkg::dram_req_t                  dram_req_o,
    output logic                                  dram_req_valid_o,
    input  logic                                  dram_req_ready_i,
    input  logic [accel_pkg::DRAM_DATA_WIDTH-1:0] dram_rsp_data_i,
    input  logic                                  dram_rsp_valid_i,
    output logic signed [accel_pkg::ACC_WIDTH-1:0] result_o,
    output logic                                  result_valid_o,
    input  logic                                  result_ready_i
);

    accel_pkg::fetch_cmd_t   in_cmd;
    accel_pkg::fetch_cmd_t   wt_cmd;
    logic                    fetch_start;
    logic                    in_done;
    logic                    wt_done;
    logic                    mac_start;
    logic [ROW_ADDR_WIDTH:0] mac_n_rows;
    logic                    mac_busy;

    accel_pkg::dram_req_t    in_req;
    logic                    in_req_valid;
    logic                    in_req_ready;
    logic                    in_rsp_valid;
    accel_pkg::dram_req_t    wt_req;
    logic                    wt_req_valid;
    logic                    wt_req_ready;
    logic                    wt_rsp_valid;

    logic [ROW_ADDR_WIDTH-1:0] in_wr_addr;
    accel_pkg::in_row_t        in_wr_data;
    logic                      in_wr_en;
    logic [ROW_ADDR_WIDTH-1:0] wt_wr_addr;
    accel_pkg::wt_row_t        wt_wr_data;
    logic                      wt_wr_en;
    logic [ROW_ADDR_WIDTH-1:0] rd_addr;
    accel_pkg::in_row_t        in_rd_row;
    accel_pkg::wt_row_t        wt_rd_row;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    layer_controller #(.ROW_ADDR_WIDTH(ROW_ADDR_WIDTH)) u_ctrl (
        .clk_i(clk_i), .rd_weight_rst(rd_weight_rst),
        .job_i(job_i), .job_valid_i(job_valid_i), .job_ready_o(job_ready_o),
        .in_cmd_o(in_cmd), .wt_cmd_o(wt_cmd), .fetch_start_o(fetch_start),
        .in_done_i(in_done), .wt_done_i(wt_done),
        .mac_start_o(mac_start), .mac_n_rows_o(mac_n_rows), .mac_busy_i(mac_busy)
    );

    ////////////////////////////////////////
    // dram fetch path
    ////////////////////////////////////////

    row_fetcher #(.row_t(accel_pkg::in_row_t), .ROW_ADDR_WIDTH(ROW_ADDR_WIDTH)) u_in_fetch (
        .clk_i(clk_i), .rd_weight_rst(rd_weight_rst),
        .cmd_i(in_cmd), .start_i(fetch_start), .done_o(in_done),
        .req_o(in_req), .req_valid_o(in_req_valid), .req_ready_i(in_req_ready),
        .rsp_valid_i(in_rsp_valid), .rsp_data_i(dram_rsp_data_i),
        .wr_addr_o(in_wr_addr), .wr_data_o(in_wr_data), .wr_en_o(in_wr_en)
    );

    row_fetcher #(.row_t(accel_pkg::wt_row_t), .ROW_ADDR_WIDTH(ROW_ADDR_WIDTH)) u_wt_fetch (
        .clk_i(clk_i), .rd_weight_rst(rd_weight_rst),
        .cmd_i(wt_cmd), .start_i(fetch_start), .done_o(wt_done),
        .req_o(wt_req), .req_valid_o(wt_req_valid), .req_ready_i(wt_req_ready),
        .rsp_valid_i(wt_rsp_valid), .rsp_data_i(dram_rsp_data_i),
        .wr_addr_o(wt_wr_addr), .wr_data_o(wt_wr_data), .wr_en_o(wt_wr_en)
    );

    dram_arbiter u_arb (
        .clk_i(clk_i), .rd_weight_rst(rd_weight_rst),
        .in_req_i(in_req), .in_req_valid_i(in_req_valid), .in_req_ready_o(in_req_ready),
        .wt_req_i(wt_req), .wt_req_valid_i(wt_req_valid), .wt_req_ready_o(wt_req_ready),
        .dram_req_o(dram_req_o), .dram_req_valid_o(dram_req_valid_o),
        .dram_req_ready_i(dram_req_ready_i), .dram_rsp_valid_i(dram_rsp_valid_i),
        .in_rsp_valid_o(in_rsp_valid), .wt_rsp_valid_o(wt_rsp_valid)
    );

    ////////////////////////////////////////
    // row storage and compute
    ////////////////////////////////////////

    row_ram #(.row_t(accel_pkg::in_row_t), .ROW_ADDR_WIDTH(ROW_ADDR_WIDTH)) u_in_ram (
        .clk_i(clk_i), .wr_addr_i(in_wr_addr), .wr_data_i(in_wr_data), .wr_en_i(in_wr_en),
        .rd_addr_i(rd_addr), .rd_data_o(in_rd_row)
    );

    row_ram #(.row_t(accel_pkg::wt_row_t), .ROW_ADDR_WIDTH(ROW_ADDR_WIDTH)) u_wt_ram (
        .clk_i(clk_i), .wr_addr_i(wt_wr_addr), .wr_data_i(wt_wr_data), .wr_en_i(wt_wr_en),
        .rd_addr_i(rd_addr), .rd_data_o(wt_rd_row)
    );

    mac_engine #(.N_LANES(N_LANES), .ROW_ADDR_WIDTH(ROW_ADDR_WIDTH)) u_mac (
        .clk_i(clk_i), .rd_weight_rst(rd_weight_rst),
        .start_i(mac_start), .n_rows_i(mac_n_rows), .rd_addr_o(rd_addr),
        .in_row_i(in_rd_row), .wt_row_i(wt_rd_row),
        .result_o(result_o), .result_valid_o(result_valid_o),
        .result_ready_i(result_ready_i), .busy_o(mac_busy)
    );

endmodule

// File: dram_model.sv
module dram_model (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  accel_pkg::dram_req_t                  req_i,
    input  logic                                  req_valid_i,
    output logic                                  req_ready_o,
    output logic [accel_pkg::DRAM_DATA_WIDTH-1:0] rsp_data_o,
    output logic                                  rsp_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW    = accel_pkg::DRAM_DATA_WIDTH;
    localparam int DEPTH = 2**accel_pkg::DRAM_ADDR_WIDTH;

    logic [DW-1:0] mem [DEPTH];
    logic [31:0]   rnd;
    int            cycle;
    int            last_due;
    logic [DW-1:0] data_q [$];
    int            due_q [$];

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rnd = lfsr_next(rnd);
            v = (v << 1) | int'(rnd[0]);
        end
        return v;
    endfunction

    // dram image, one lfsr bit per memory bit
    initial begin
        logic [31:0] s;
        req_ready_o = 1'b0;
        rsp_valid_o = 1'b0;
        rsp_data_o  = '0;
        s = 32'hb669_964e;
        for (int a = 0; a < DEPTH; a++) begin
            for (int b = 0; b < DW; b++) begin
                s = lfsr_next(s);
                mem[a][b] = s[0];
            end
        end
    end

    ////////////////////////////////////////
    // request stalls and in-order responses
    ////////////////////////////////////////

    always @(posedge clk_i) begin
        int lat;
        if (rst_i) begin
            rnd      = 32'hb669_964e;
            cycle    = 0;
            last_due = 0;
            data_q.delete();
            due_q.delete();
            #1;
            req_ready_o = 1'b0;
            rsp_valid_o = 1'b0;
            rsp_data_o  = '0;
        end else begin
            cycle++;
            if (rsp_valid_o) begin
                void'(data_q.pop_front());
                void'(due_q.pop_front());
            end
            if (req_valid_i && req_ready_o) begin
                // latency of 1 to 4 cycles, never overtaking an older request
                lat = 1 + take_bits(2);
                if (cycle + lat > last_due) begin
                    last_due = cycle + lat;
                end
                data_q.push_back(mem[req_i.addr]);
                due_q.push_back(last_due);
            end
            #1;
            req_ready_o = (take_bits(2) != 0);
            rsp_valid_o = (due_q.size() > 0) && (due_q[0] <= cycle);
            rsp_data_o  = rsp_valid_o ? data_q[0] : '0;
        end
    end

endmodule

// File: tb_conv_accel.sv
module tb_conv_accel;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RAND_JOBS    = 6;
    localparam int JOB_TIMEOUT    = 200;
    localparam int RESULT_TIMEOUT = 5000;
    localparam int LANES          = 8;
    localparam int LANE_W         = 8;

    logic                   clk_i;
    logic                   rd_weight_rst;
    accel_pkg::job_t        job_i;
    logic                   job_valid_i;
    logic                   job_ready_o;
    accel_pkg::dram_req_t   dram_req_o;
    logic                   dram_req_valid_o;
    logic                   dram_req_ready_i;
    logic [31:0]            dram_rsp_data_i;
    logic                   dram_rsp_valid_i;
    logic signed [31:0]     result_o;
    logic                   result_valid_o;
    logic                   result_ready_i;

    logic [31:0]        rnd;
    logic               stop_run;
    int                 checks;
    int                 errors;
    int                 timeouts;
    int                 addr_hits [int];
    logic [17:0]        cur_in_base;
    logic [17:0]        cur_wt_base;
    int                 cur_rows;
    logic               in_reset_d;
    logic               job_busy;
    logic               stall_d;
    logic signed [31:0] held_result;
    logic [17:0]        rand_in [N_RAND_JOBS];
    logic [17:0]        rand_wt [N_RAND_JOBS];
    int                 rand_rows [N_RAND_JOBS];

    conv_accel_top #(
        .N_LANES(accel_pkg::N_LANES),
        .ROW_ADDR_WIDTH(accel_pkg::ROW_ADDR_WIDTH)
    ) uut (
        .clk_i(clk_i), .rd_weight_rst(rd_weight_rst),
        .job_i(job_i), .job_valid_i(job_valid_i), .job_ready_o(job_ready_o),
        .dram_req_o(dram_req_o), .dram_req_valid_o(dram_req_valid_o),
        .dram_req_ready_i(dram_req_ready_i),
        .dram_rsp_data_i(dram_rsp_data_i), .dram_rsp_valid_i(dram_rsp_valid_i),
        .result_o(result_o), .result_valid_o(result_valid_o), .result_ready_i(result_ready_i)
    );

    dram_model u_dram (
        .clk_i(clk_i), .rst_i(rd_weight_rst),
        .req_i(dram_req_o), .req_valid_i(dram_req_valid_o), .req_ready_o(dram_req_ready_i),
        .rsp_data_o(dram_rsp_data_i), .rsp_valid_o(dram_rsp_valid_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            rnd = lfsr_next(rnd);
            v = (v << 1) | int'(rnd[0]);
        end
        return v;
    endfunction

    // reference dot product straight from the dram image, word 0 in the low bits
    function automatic int expected_sum(input logic [17:0] in_base, input logic [17:0] wt_base,
                                        input int rows);
        logic [63:0] in_row;
        logic [63:0] wt_row;
        int          a;
        int          b;
        int          sum;
        sum = 0;
        for (int r = 0; r < rows; r++) begin
            in_row = {u_dram.mem[in_base + 18'(2 * r + 1)], u_dram.mem[in_base + 18'(2 * r)]};
            wt_row = {u_dram.mem[wt_base + 18'(2 * r + 1)], u_dram.mem[wt_base + 18'(2 * r)]};
            for (int l = 0; l < LANES; l++) begin
                a = $signed(in_row[LANE_W*l +: LANE_W]);
                b = $signed(wt_row[LANE_W*l +: LANE_W]);
                sum += a * b;
            end
        end
        return sum;
    endfunction

    task automatic check_eq(input string name, input longint expected, input longint actual);
        checks++;
        assert (expected == actual) else begin
            $display("FAIL %s: expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_request(input logic [17:0] addr);
        logic in_rng;
        logic wt_rng;
        in_rng = (addr >= cur_in_base) && (int'(addr) < int'(cur_in_base) + 2 * cur_rows);
        wt_rng = (addr >= cur_wt_base) && (int'(addr) < int'(cur_wt_base) + 2 * cur_rows);
        checks++;
        assert (in_rng || wt_rng) else begin
            $display("FAIL addr_range: expected %h+%0d or %h+%0d actual %h",
                     cur_in_base, 2 * cur_rows, cur_wt_base, 2 * cur_rows, addr);
            errors++;
        end
        if (addr_hits.exists(int'(addr))) begin
            addr_hits[int'(addr)]++;
        end else begin
            addr_hits[int'(addr)] = 1;
        end
    endtask

    function automatic int hits_at(input int addr);
        return addr_hits.exists(addr) ? addr_hits[addr] : 0;
    endfunction

    // every word of both ranges read once
    task automatic check_addresses(input int idx);
        for (int r = 0; r < 2 * cur_rows; r++) begin
            check_eq($sformatf("addr_once job %0d in+%0d", idx, r), 1,
                     hits_at(int'(cur_in_base) + r));
            check_eq($sformatf("addr_once job %0d wt+%0d", idx, r), 1,
                     hits_at(int'(cur_wt_base) + r));
        end
    endtask

    ////////////////////////////////////////
    // job sequencing
    ////////////////////////////////////////

    task automatic run_job(input int idx, input logic [17:0] ib, input logic [17:0] wb,
                           input int rows);
        int t;
        int expected;
        expected    = expected_sum(ib, wb, rows);
        cur_in_base = ib;
        cur_wt_base = wb;
        cur_rows    = rows;
        addr_hits.delete();
        job_i       = '{in_base: ib, wt_base: wb, n_rows: 5'(rows)};
        job_valid_i = 1'b1;
        t = 0;
        @(negedge clk_i);
        while (!job_ready_o) begin
            t++;
            if (t > JOB_TIMEOUT) begin
                $display("timeout: job %0d was never accepted", idx);
                timeouts++;
                stop_run = 1'b1;
                return;
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        job_valid_i = 1'b0;
        t = 0;
        @(negedge clk_i);
        while (!(result_valid_o && result_ready_i)) begin
            t++;
            if (t > RESULT_TIMEOUT) begin
                $display("timeout: job %0d never returned a result", idx);
                timeouts++;
                stop_run = 1'b1;
                return;
            end
            @(negedge clk_i);
        end
        check_eq($sformatf("result_value job %0d", idx), expected, result_o);
        @(posedge clk_i);
        #1;
        check_addresses(idx);
    endtask

    // random back-pressure on the result port
    initial begin
        result_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            result_ready_i = (take_bits(1) != 0);
        end
    end

    ////////////////////////////////////////
    // monitors, sampled mid-cycle
    ////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rd_weight_rst || in_reset_d) begin
            check_eq("reset_req_valid", 0, dram_req_valid_o);
            check_eq("reset_result_valid", 0, result_valid_o);
        end
        in_reset_d = rd_weight_rst;
        if (!rd_weight_rst) begin
            if (dram_req_valid_o && dram_req_ready_i) begin
                note_request(dram_req_o.addr);
            end
            if (stall_d) begin
                check_eq("hold_result_valid", 1, result_valid_o);
                check_eq("hold_result", held_result, result_o);
            end
            stall_d     = result_valid_o && !result_ready_i;
            held_result = result_o;
            if (job_busy) begin
                check_eq("busy_job_ready", 0, job_ready_o);
            end
            if (job_valid_i && job_ready_o) begin
                job_busy = 1'b1;
            end
            if (result_valid_o && result_ready_i) begin
                job_busy = 1'b0;
            end
        end
    end

    initial begin
        rd_weight_rst = 1'b1;
        job_valid_i   = 1'b0;
        job_i         = '0;
        rnd           = 32'hb669_964e;
        stop_run      = 1'b0;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        in_reset_d    = 1'b1;
        job_busy      = 1'b0;
        stall_d       = 1'b0;
        held_result   = '0;
        cur_in_base   = '0;
        cur_wt_base   = '0;
        cur_rows      = 0;
        // input and weight windows kept apart
        for (int j = 0; j < N_RAND_JOBS; j++) begin
            rand_in[j]   = 18'(take_bits(12));
            rand_wt[j]   = 18'h20000 + 18'(take_bits(12));
            rand_rows[j] = 1 + take_bits(4);
        end
        repeat (5) @(posedge clk_i);
        #1;
        rd_weight_rst = 1'b0;
        run_job(0, 18'h00100, 18'h00800, 4);
        if (!stop_run) begin
            run_job(1, 18'h01000, 18'h01800, 1);
        end
        if (!stop_run) begin
            run_job(2, 18'h02000, 18'h3ffc0, 16);
        end
        // back-to-back jobs
        for (int j = 0; j < N_RAND_JOBS && !stop_run; j++) begin
            run_job(3 + j, rand_in[j], rand_wt[j], rand_rows[j]);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: all.f
accel_pkg.sv
dram_arbiter.sv
row_fetcher.sv
row_ram.sv
mac_engine.sv
layer_controller.sv
conv_accel_top.sv
dram_model.sv
tb_conv_accel.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_conv_accel -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "no pass message in $LOG"
    exit 1
fi
exit 0
